// File: design/pcs_rx_macros.svh
`ifndef PCS_RX_MACROS_SVH
`define PCS_RX_MACROS_SVH

// Lane count of the receive word
`define PCS_LANES 4

// 66b block split into sync header and payload
`define BLK_DATA_W 64
`define SYNC_W 2

// Descrambler polynomial 1 + x^39 + x^58
`define SCR_LEN 58
`define SCR_TAP 39

// Errored-block counter
`define ERRBLK_W 8

`endif

// File: design/pcs_block_pkg.sv
`include "pcs_rx_macros.svh"

package pcs_block_pkg;

    ////////////////////
    // Block fields
    ////////////////////

    typedef logic [`BLK_DATA_W-1:0] blk_data_t;
    typedef logic [`SYNC_W-1:0]     sync_hdr_t;
    typedef logic [`SCR_LEN-1:0]    scr_hist_t;

    // Type field sits in payload byte 0 of a control block
    typedef logic [7:0]             blk_type_t;

    ////////////////////
    // Sync headers
    ////////////////////

    localparam sync_hdr_t SYNC_DATA = 2'b01;
    localparam sync_hdr_t SYNC_CTRL = 2'b10;

    ////////////////////
    // Control block types
    ////////////////////

    // All idle
    localparam blk_type_t BT_IDLE  = 8'h1E;
    // Start in byte 0, data in bytes 1 to 7
    localparam blk_type_t BT_START = 8'h78;
    // Terminate in byte 0
    localparam blk_type_t BT_TERM0 = 8'h87;
    // Seven data bytes then terminate
    localparam blk_type_t BT_TERM7 = 8'hFF;

endpackage

// File: design/xgmii_pkg.sv
package xgmii_pkg;

    ////////////////////
    // XGMII lane types
    ////////////////////

    // Bit n flags byte n as a control character
    typedef logic [7:0]  xgmii_ctrl_t;
    typedef logic [63:0] xgmii_data_t;
    typedef logic [7:0]  xgmii_char_t;

    ////////////////////
    // Control characters
    ////////////////////

    localparam xgmii_char_t XG_IDLE  = 8'h07;
    localparam xgmii_char_t XG_START = 8'hFB;
    localparam xgmii_char_t XG_TERM  = 8'hFD;
    localparam xgmii_char_t XG_ERROR = 8'hFE;

endpackage

// File: design/lane_descrambler.sv
`timescale 1ns/10ps
`include "pcs_rx_macros.svh"

module lane_descrambler (
    input  logic                     rx_clk_161_13,
    input  logic                     async_reset_n,
    input  logic                     blk_valid_i,
    input  logic                     bypass_descram_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_0_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_1_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_2_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_3_i,
    input  pcs_block_pkg::blk_data_t blk_data_0_i,
    input  pcs_block_pkg::blk_data_t blk_data_1_i,
    input  pcs_block_pkg::blk_data_t blk_data_2_i,
    input  pcs_block_pkg::blk_data_t blk_data_3_i,
    output logic                     descr_valid_o,
    output pcs_block_pkg::sync_hdr_t sync_hdr_0_o,
    output pcs_block_pkg::sync_hdr_t sync_hdr_1_o,
    output pcs_block_pkg::sync_hdr_t sync_hdr_2_o,
    output pcs_block_pkg::sync_hdr_t sync_hdr_3_o,
    output pcs_block_pkg::blk_data_t descr_data_0_o,
    output pcs_block_pkg::blk_data_t descr_data_1_o,
    output pcs_block_pkg::blk_data_t descr_data_2_o,
    output pcs_block_pkg::blk_data_t descr_data_3_o
);
    import pcs_block_pkg::*;

    localparam int EXT_W = `BLK_DATA_W + `SCR_LEN;

    sync_hdr_t rx_hdr    [`PCS_LANES];
    blk_data_t rx_data   [`PCS_LANES];
    scr_hist_t prev_bits [`PCS_LANES];
    blk_data_t plain     [`PCS_LANES];
    sync_hdr_t hdr_q     [`PCS_LANES];
    blk_data_t data_q    [`PCS_LANES];
    scr_hist_t hist_q;

    // out[i] = in[i] ^ in[i-39] ^ in[i-58] with older bits from prev
    function automatic blk_data_t descramble(input blk_data_t rx, input scr_hist_t prev);
        logic [EXT_W-1:0] ext;
        blk_data_t        res;
        ext = {rx, prev};
        for (int i = 0; i < `BLK_DATA_W; i++) begin
            res[i] = ext[i + `SCR_LEN] ^ ext[i + `SCR_LEN - `SCR_TAP] ^ ext[i];
        end
        return res;
    endfunction

    assign rx_hdr[0]  = sync_hdr_0_i;
    assign rx_hdr[1]  = sync_hdr_1_i;
    assign rx_hdr[2]  = sync_hdr_2_i;
    assign rx_hdr[3]  = sync_hdr_3_i;
    assign rx_data[0] = blk_data_0_i;
    assign rx_data[1] = blk_data_1_i;
    assign rx_data[2] = blk_data_2_i;
    assign rx_data[3] = blk_data_3_i;

    ////////////////////
    // Lane chain
    ////////////////////

    // Lane 0 continues from last word's lane 3
    assign prev_bits[0] = hist_q;

    for (genvar n = 0; n < `PCS_LANES; n++) begin : g_lane
        if (n > 0) begin : g_prev
            assign prev_bits[n] = rx_data[n-1][`BLK_DATA_W-1 -: `SCR_LEN];
        end
        assign plain[n] = bypass_descram_i ? rx_data[n] : descramble(rx_data[n], prev_bits[n]);
    end

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            descr_valid_o <= 1'b0;
            hist_q        <= '0;
        end else begin
            descr_valid_o <= blk_valid_i;
            // Keeps following the line in bypass as well
            if (blk_valid_i) begin
                hist_q <= rx_data[`PCS_LANES-1][`BLK_DATA_W-1 -: `SCR_LEN];
            end
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (blk_valid_i) begin
            for (int n = 0; n < `PCS_LANES; n++) begin
                hdr_q[n]  <= rx_hdr[n];
                data_q[n] <= plain[n];
            end
        end
    end

    assign sync_hdr_0_o   = hdr_q[0];
    assign sync_hdr_1_o   = hdr_q[1];
    assign sync_hdr_2_o   = hdr_q[2];
    assign sync_hdr_3_o   = hdr_q[3];
    assign descr_data_0_o = data_q[0];
    assign descr_data_1_o = data_q[1];
    assign descr_data_2_o = data_q[2];
    assign descr_data_3_o = data_q[3];

    a_valid_known: assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        !$isunknown(descr_valid_o)
    );

endmodule

// File: design/block_decoder.sv
`timescale 1ns/10ps

module block_decoder (
    input  logic                     rx_clk_161_13,
    input  logic                     async_reset_n,
    input  logic                     descr_valid_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_i,
    input  pcs_block_pkg::blk_data_t blk_data_i,
    input  logic                     terminate_i,
    output logic                     terminate_o,
    output logic                     xgmii_valid_o,
    output xgmii_pkg::xgmii_ctrl_t   xgmii_ctrl_o,
    output xgmii_pkg::xgmii_data_t   xgmii_data_o,
    output logic                     blk_err_o
);
    import pcs_block_pkg::*;
    import xgmii_pkg::*;

    typedef enum logic [2:0] {
        CLS_DATA,
        CLS_IDLE,
        CLS_START,
        CLS_TERM0,
        CLS_TERM7,
        CLS_ERROR
    } blk_class_t;

    blk_type_t   blk_type;
    blk_class_t  raw_class;
    blk_class_t  blk_class;
    xgmii_ctrl_t dec_ctrl;
    xgmii_data_t dec_data;

    assign blk_type = blk_data_i[7:0];

    ////////////////////
    // Classification
    ////////////////////

    always_comb begin
        raw_class = CLS_ERROR;
        if (sync_hdr_i == SYNC_DATA) begin
            raw_class = CLS_DATA;
        end else if (sync_hdr_i == SYNC_CTRL) begin
            case (blk_type)
                BT_IDLE: begin
                    raw_class = CLS_IDLE;
                end
                BT_START: begin
                    raw_class = CLS_START;
                end
                BT_TERM0: begin
                    raw_class = CLS_TERM0;
                end
                BT_TERM7: begin
                    raw_class = CLS_TERM7;
                end
                default: begin
                    raw_class = CLS_ERROR;
                end
            endcase
        end
    end

    assign terminate_o = (raw_class == CLS_TERM0) || (raw_class == CLS_TERM7);

    // Only idle may follow a terminate in a lower lane
    assign blk_class = (terminate_i && (raw_class != CLS_IDLE)) ? CLS_ERROR : raw_class;

    ////////////////////
    // XGMII mapping
    ////////////////////

    always_comb begin
        dec_ctrl = 8'hFF;
        dec_data = {8{XG_ERROR}};
        case (blk_class)
            CLS_DATA: begin
                dec_ctrl = 8'h00;
                dec_data = blk_data_i;
            end
            CLS_IDLE: begin
                dec_ctrl = 8'hFF;
                dec_data = {8{XG_IDLE}};
            end
            CLS_START: begin
                dec_ctrl = 8'h01;
                dec_data = {blk_data_i[63:8], XG_START};
            end
            CLS_TERM0: begin
                dec_ctrl = 8'hFF;
                dec_data = {{7{XG_IDLE}}, XG_TERM};
            end
            CLS_TERM7: begin
                // Payload bytes 1 to 7 shift down to lanes 0 to 6
                dec_ctrl = 8'h80;
                dec_data = {XG_TERM, blk_data_i[63:8]};
            end
            default: begin
                dec_ctrl = 8'hFF;
                dec_data = {8{XG_ERROR}};
            end
        endcase
    end

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            xgmii_valid_o <= 1'b0;
            blk_err_o     <= 1'b0;
        end else begin
            xgmii_valid_o <= descr_valid_i;
            if (descr_valid_i) begin
                blk_err_o <= (blk_class == CLS_ERROR);
            end
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (descr_valid_i) begin
            xgmii_ctrl_o <= dec_ctrl;
            xgmii_data_o <= dec_data;
        end
    end

    a_err_ctrl: assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        blk_err_o |-> (xgmii_ctrl_o == 8'hFF)
    );

endmodule

// File: design/pcs_rx_top.sv
`timescale 1ns/10ps
`include "pcs_rx_macros.svh"

module pcs_rx_top (
    input  logic                     rx_clk_161_13,
    input  logic                     async_reset_n,
    input  logic                     blk_valid_i,
    input  logic                     bypass_descram_i,
    input  logic                     clear_errblk_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_0_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_1_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_2_i,
    input  pcs_block_pkg::sync_hdr_t sync_hdr_3_i,
    input  pcs_block_pkg::blk_data_t blk_data_0_i,
    input  pcs_block_pkg::blk_data_t blk_data_1_i,
    input  pcs_block_pkg::blk_data_t blk_data_2_i,
    input  pcs_block_pkg::blk_data_t blk_data_3_i,
    output logic                     xgmii_valid_o,
    output xgmii_pkg::xgmii_ctrl_t   xgmii_ctrl_0_o,
    output xgmii_pkg::xgmii_ctrl_t   xgmii_ctrl_1_o,
    output xgmii_pkg::xgmii_ctrl_t   xgmii_ctrl_2_o,
    output xgmii_pkg::xgmii_ctrl_t   xgmii_ctrl_3_o,
    output xgmii_pkg::xgmii_data_t   xgmii_data_0_o,
    output xgmii_pkg::xgmii_data_t   xgmii_data_1_o,
    output xgmii_pkg::xgmii_data_t   xgmii_data_2_o,
    output xgmii_pkg::xgmii_data_t   xgmii_data_3_o,
    output logic [`ERRBLK_W-1:0]     errd_blks_o
);
    import pcs_block_pkg::*;
    import xgmii_pkg::*;

    localparam int SUM_W = $clog2(`PCS_LANES + 1);
    localparam int CNT_W = `ERRBLK_W + 1;

    logic                  descr_valid;
    sync_hdr_t             descr_hdr  [`PCS_LANES];
    blk_data_t             descr_data [`PCS_LANES];
    logic [`PCS_LANES-1:0] term_out;
    logic [`PCS_LANES-1:0] term_in;
    logic [`PCS_LANES-1:0] dec_valid;
    logic [`PCS_LANES-1:0] dec_err;
    xgmii_ctrl_t           dec_ctrl   [`PCS_LANES];
    xgmii_data_t           dec_data   [`PCS_LANES];
    logic [SUM_W-1:0]      err_sum;
    logic [CNT_W-1:0]      cnt_sum;

    lane_descrambler u_descr (
        .rx_clk_161_13    (rx_clk_161_13),
        .async_reset_n    (async_reset_n),
        .blk_valid_i      (blk_valid_i),
        .bypass_descram_i (bypass_descram_i),
        .sync_hdr_0_i     (sync_hdr_0_i),
        .sync_hdr_1_i     (sync_hdr_1_i),
        .sync_hdr_2_i     (sync_hdr_2_i),
        .sync_hdr_3_i     (sync_hdr_3_i),
        .blk_data_0_i     (blk_data_0_i),
        .blk_data_1_i     (blk_data_1_i),
        .blk_data_2_i     (blk_data_2_i),
        .blk_data_3_i     (blk_data_3_i),
        .descr_valid_o    (descr_valid),
        .sync_hdr_0_o     (descr_hdr[0]),
        .sync_hdr_1_o     (descr_hdr[1]),
        .sync_hdr_2_o     (descr_hdr[2]),
        .sync_hdr_3_o     (descr_hdr[3]),
        .descr_data_0_o   (descr_data[0]),
        .descr_data_1_o   (descr_data[1]),
        .descr_data_2_o   (descr_data[2]),
        .descr_data_3_o   (descr_data[3])
    );

    // Lane n sees a terminate anywhere below it
    always_comb begin
        term_in[0] = 1'b0;
        for (int n = 1; n < `PCS_LANES; n++) begin
            term_in[n] = term_in[n-1] | term_out[n-1];
        end
    end

    for (genvar n = 0; n < `PCS_LANES; n++) begin : g_dec
        block_decoder u_dec (
            .rx_clk_161_13 (rx_clk_161_13),
            .async_reset_n (async_reset_n),
            .descr_valid_i (descr_valid),
            .sync_hdr_i    (descr_hdr[n]),
            .blk_data_i    (descr_data[n]),
            .terminate_i   (term_in[n]),
            .terminate_o   (term_out[n]),
            .xgmii_valid_o (dec_valid[n]),
            .xgmii_ctrl_o  (dec_ctrl[n]),
            .xgmii_data_o  (dec_data[n]),
            .blk_err_o     (dec_err[n])
        );
    end

    assign xgmii_valid_o  = dec_valid[0];
    assign xgmii_ctrl_0_o = dec_ctrl[0];
    assign xgmii_ctrl_1_o = dec_ctrl[1];
    assign xgmii_ctrl_2_o = dec_ctrl[2];
    assign xgmii_ctrl_3_o = dec_ctrl[3];
    assign xgmii_data_0_o = dec_data[0];
    assign xgmii_data_1_o = dec_data[1];
    assign xgmii_data_2_o = dec_data[2];
    assign xgmii_data_3_o = dec_data[3];

    ////////////////////
    // Errored blocks
    ////////////////////

    always_comb begin
        err_sum = '0;
        for (int n = 0; n < `PCS_LANES; n++) begin
            err_sum = err_sum + SUM_W'(dec_valid[n] & dec_err[n]);
        end
    end

    assign cnt_sum = {1'b0, errd_blks_o} + CNT_W'(err_sum);

    always_ff @(posedge rx_clk_161_13 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            errd_blks_o <= '0;
        end else if (clear_errblk_i) begin
            errd_blks_o <= '0;
        end else if (cnt_sum[`ERRBLK_W]) begin
            // Saturate
            errd_blks_o <= '1;
        end else begin
            errd_blks_o <= cnt_sum[`ERRBLK_W-1:0];
        end
    end

    a_cnt_monotonic: assert property (
        @(posedge rx_clk_161_13) disable iff (!async_reset_n)
        !clear_errblk_i |=> (errd_blks_o >= $past(errd_blks_o))
    );

endmodule

// File: dv/pcs_rx_tb.sv
`timescale 1ns/10ps
`include "pcs_rx_macros.svh"

module pcs_rx_tb;
    import pcs_block_pkg::*;
    import xgmii_pkg::*;

    localparam int MAX_ROWS      = 16;
    localparam int VALID_TIMEOUT = 20;
    localparam int CNT_MAX       = (1 << `ERRBLK_W) - 1;

    logic                 rx_clk_161_13;
    logic                 async_reset_n;
    logic                 blk_valid;
    logic                 bypass_descram;
    logic                 clear_errblk;
    sync_hdr_t            hdr_drv  [`PCS_LANES];
    blk_data_t            data_drv [`PCS_LANES];
    logic                 xgmii_valid;
    xgmii_ctrl_t          got_ctrl [`PCS_LANES];
    xgmii_data_t          got_data [`PCS_LANES];
    logic [`ERRBLK_W-1:0] errd_blks;

    // Stimulus and expected values per word
    sync_hdr_t   t_hdr  [MAX_ROWS][`PCS_LANES];
    blk_data_t   t_pl   [MAX_ROWS][`PCS_LANES];
    logic        t_rnd  [MAX_ROWS][`PCS_LANES];
    logic        t_byp  [MAX_ROWS];
    xgmii_ctrl_t t_ctrl [MAX_ROWS][`PCS_LANES];
    xgmii_data_t t_data [MAX_ROWS][`PCS_LANES];
    logic        t_err  [MAX_ROWS][`PCS_LANES];
    int          n_rows;

    logic [31:0] lfsr;
    scr_hist_t   scr_hist;
    int          exp_cnt;
    int          n_checks;
    int          n_errors;
    bit          timed_out;

    always #20 rx_clk_161_13 = ~rx_clk_161_13;

    pcs_rx_top dut (
        .rx_clk_161_13    (rx_clk_161_13),
        .async_reset_n    (async_reset_n),
        .blk_valid_i      (blk_valid),
        .bypass_descram_i (bypass_descram),
        .clear_errblk_i   (clear_errblk),
        .sync_hdr_0_i     (hdr_drv[0]),
        .sync_hdr_1_i     (hdr_drv[1]),
        .sync_hdr_2_i     (hdr_drv[2]),
        .sync_hdr_3_i     (hdr_drv[3]),
        .blk_data_0_i     (data_drv[0]),
        .blk_data_1_i     (data_drv[1]),
        .blk_data_2_i     (data_drv[2]),
        .blk_data_3_i     (data_drv[3]),
        .xgmii_valid_o    (xgmii_valid),
        .xgmii_ctrl_0_o   (got_ctrl[0]),
        .xgmii_ctrl_1_o   (got_ctrl[1]),
        .xgmii_ctrl_2_o   (got_ctrl[2]),
        .xgmii_ctrl_3_o   (got_ctrl[3]),
        .xgmii_data_0_o   (got_data[0]),
        .xgmii_data_1_o   (got_data[1]),
        .xgmii_data_2_o   (got_data[2]),
        .xgmii_data_3_o   (got_data[3]),
        .errd_blks_o      (errd_blks)
    );

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic blk_data_t rand_word();
        blk_data_t w;
        for (int i = 0; i < `BLK_DATA_W; i++) begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];
        end
        return w;
    endfunction

    function automatic blk_data_t ctrl_payload(input logic [55:0] rest, input blk_type_t t);
        return {rest, t};
    endfunction

    // Transmit side scrambler s[i] = p[i] ^ s[i-39] ^ s[i-58]
    task automatic scramble_lane(input blk_data_t p, input logic byp, output blk_data_t s);
        logic [`BLK_DATA_W+`SCR_LEN-1:0] ext;
        ext = '0;
        ext[`SCR_LEN-1:0] = scr_hist;
        for (int i = 0; i < `BLK_DATA_W; i++) begin
            ext[`SCR_LEN + i] = p[i] ^ ext[`SCR_LEN - `SCR_TAP + i] ^ ext[i];
        end
        s = byp ? p : ext[`BLK_DATA_W+`SCR_LEN-1:`SCR_LEN];
        // Receiver history follows the line bits either way
        scr_hist = s[`BLK_DATA_W-1 -: `SCR_LEN];
    endtask

    task automatic set_lane(input int n, input sync_hdr_t h, input blk_data_t pl,
                            input xgmii_ctrl_t c, input xgmii_data_t d, input logic e);
        t_hdr[n_rows][n]  = h;
        t_pl[n_rows][n]   = pl;
        t_rnd[n_rows][n]  = 1'b0;
        t_ctrl[n_rows][n] = c;
        t_data[n_rows][n] = d;
        t_err[n_rows][n]  = e;
    endtask

    task automatic set_rand_lane(input int n);
        set_lane(n, SYNC_DATA, '0, 8'h00, '0, 1'b0);
        t_rnd[n_rows][n] = 1'b1;
    endtask

    task automatic close_row(input logic byp);
        t_byp[n_rows] = byp;
        n_rows++;
    endtask

    ////////////////////
    // Table
    ////////////////////

    task automatic build_table();
        xgmii_data_t all_idle;
        xgmii_data_t all_err;
        all_idle = {8{XG_IDLE}};
        all_err  = {8{XG_ERROR}};
        // Random data words chaining the history
        for (int w = 0; w < 4; w++) begin
            for (int n = 0; n < `PCS_LANES; n++) begin
                set_rand_lane(n);
            end
            close_row(1'b0);
        end
        // Start, data, data, terminate-7
        set_lane(0, SYNC_CTRL, ctrl_payload(56'h11223344556677, BT_START),
                 8'h01, 64'h1122_3344_5566_77FB, 1'b0);
        set_lane(1, SYNC_DATA, 64'h0123_4567_89ab_cdef, 8'h00, 64'h0123_4567_89ab_cdef, 1'b0);
        set_lane(2, SYNC_DATA, 64'hfedc_ba98_7654_3210, 8'h00, 64'hfedc_ba98_7654_3210, 1'b0);
        set_lane(3, SYNC_CTRL, ctrl_payload(56'hA1A2A3A4A5A6A7, BT_TERM7),
                 8'h80, 64'hFDA1_A2A3_A4A5_A6A7, 1'b0);
        close_row(1'b0);
        // Terminate-0 in lane 1 with idle above it
        set_rand_lane(0);
        set_lane(1, SYNC_CTRL, ctrl_payload('0, BT_TERM0), 8'hFF, 64'h0707_0707_0707_07FD, 1'b0);
        set_lane(2, SYNC_CTRL, ctrl_payload('0, BT_IDLE), 8'hFF, all_idle, 1'b0);
        set_lane(3, SYNC_CTRL, ctrl_payload('0, BT_IDLE), 8'hFF, all_idle, 1'b0);
        close_row(1'b0);
        // Same word with data after the terminate
        set_rand_lane(0);
        set_lane(1, SYNC_CTRL, ctrl_payload('0, BT_TERM0), 8'hFF, 64'h0707_0707_0707_07FD, 1'b0);
        set_lane(2, SYNC_CTRL, ctrl_payload('0, BT_IDLE), 8'hFF, all_idle, 1'b0);
        set_lane(3, SYNC_DATA, 64'h5555_aaaa_5555_aaaa, 8'hFF, all_err, 1'b1);
        close_row(1'b0);
        // Bypass words
        set_lane(0, SYNC_CTRL, ctrl_payload('0, BT_IDLE), 8'hFF, all_idle, 1'b0);
        for (int n = 1; n < `PCS_LANES; n++) begin
            set_rand_lane(n);
        end
        close_row(1'b1);
        for (int n = 0; n < `PCS_LANES; n++) begin
            set_rand_lane(n);
        end
        close_row(1'b1);
        for (int n = 0; n < `PCS_LANES; n++) begin
            set_rand_lane(n);
        end
        close_row(1'b0);
        // Bad headers and an unknown type
        set_lane(0, 2'b00, 64'h0000_0000_0000_0001, 8'hFF, all_err, 1'b1);
        set_lane(1, SYNC_CTRL, ctrl_payload(56'h0, 8'h4B), 8'hFF, all_err, 1'b1);
        set_lane(2, 2'b11, 64'h1234_5678_9abc_def0, 8'hFF, all_err, 1'b1);
        set_lane(3, SYNC_DATA, 64'h0f0f_0f0f_0f0f_0f0f, 8'h00, 64'h0f0f_0f0f_0f0f_0f0f, 1'b0);
        close_row(1'b0);
        for (int n = 0; n < `PCS_LANES; n++) begin
            set_rand_lane(n);
        end
        close_row(1'b0);
    endtask

    ////////////////////
    // Apply and check
    ////////////////////

    task automatic report_mismatch(input string what, input int r, input int n,
                                   input logic [63:0] got, input logic [63:0] exp);
        $display("CHECK FAILED @%0t: row %0d lane %0d %s got %h expected %h",
                 $time, r, n, what, got, exp);
        n_errors++;
    endtask

    task automatic wait_for_valid(output int lat, output bit ok);
        int cycles;
        cycles = 1;
        ok = xgmii_valid;
        while (!ok && cycles < VALID_TIMEOUT) begin
            @(negedge rx_clk_161_13);
            cycles++;
            ok = xgmii_valid;
        end
        lat = cycles;
    endtask

    task automatic apply_row(input int r);
        blk_data_t pl;
        blk_data_t line;
        int        lat;
        bit        ok;
        @(negedge rx_clk_161_13);
        for (int n = 0; n < `PCS_LANES; n++) begin
            pl = t_pl[r][n];
            if (t_rnd[r][n]) begin
                pl = rand_word();
                t_data[r][n] = pl;
            end
            scramble_lane(pl, t_byp[r], line);
            hdr_drv[n]  = t_hdr[r][n];
            data_drv[n] = line;
        end
        bypass_descram = t_byp[r];
        blk_valid      = 1'b1;
        @(negedge rx_clk_161_13);
        blk_valid = 1'b0;
        wait_for_valid(lat, ok);
        if (!ok) begin
            timed_out = 1'b1;
            $display("xgmii_valid_o did not rise within %0d cycles of the strobe for row %0d",
                     VALID_TIMEOUT, r);
        end else begin
            n_checks++;
            if (lat != 2) begin
                report_mismatch("latency", r, 0, 64'(lat), 64'd2);
            end
            for (int n = 0; n < `PCS_LANES; n++) begin
                n_checks++;
                if (got_ctrl[n] != t_ctrl[r][n]) begin
                    report_mismatch("ctrl", r, n, 64'(got_ctrl[n]), 64'(t_ctrl[r][n]));
                end
                n_checks++;
                if (got_data[n] != t_data[r][n]) begin
                    report_mismatch("data", r, n, got_data[n], t_data[r][n]);
                end
                if (t_err[r][n] && exp_cnt < CNT_MAX) begin
                    exp_cnt++;
                end
            end
            @(negedge rx_clk_161_13);
            n_checks++;
            if (int'(errd_blks) != exp_cnt) begin
                report_mismatch("errd_blks", r, 0, 64'(errd_blks), 64'(exp_cnt));
            end
            n_checks++;
            if (xgmii_valid) begin
                report_mismatch("valid pulse", r, 0, 64'(xgmii_valid), 64'd0);
            end
        end
    endtask

    initial begin
        int r;
        rx_clk_161_13  = 1'b0;
        async_reset_n  = 1'b0;
        blk_valid      = 1'b0;
        bypass_descram = 1'b0;
        clear_errblk   = 1'b0;
        for (int n = 0; n < `PCS_LANES; n++) begin
            hdr_drv[n]  = SYNC_DATA;
            data_drv[n] = '0;
        end
        lfsr      = 32'h9cdc_4852;
        scr_hist  = '0;
        exp_cnt   = 0;
        n_checks  = 0;
        n_errors  = 0;
        timed_out = 1'b0;
        n_rows    = 0;
        build_table();
        repeat (2) @(negedge rx_clk_161_13);
        async_reset_n = 1'b1;

        r = 0;
        while (r < n_rows && !timed_out) begin
            apply_row(r);
            r++;
        end

        // Counter clear
        if (!timed_out) begin
            @(negedge rx_clk_161_13);
            clear_errblk = 1'b1;
            @(negedge rx_clk_161_13);
            clear_errblk = 1'b0;
            exp_cnt = 0;
            n_checks++;
            if (int'(errd_blks) != exp_cnt) begin
                report_mismatch("errd_blks after clear", 0, 0, 64'(errd_blks), 64'(exp_cnt));
            end
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+design
design/pcs_block_pkg.sv
design/xgmii_pkg.sv
design/lane_descrambler.sv
design/block_decoder.sv
design/pcs_rx_top.sv
dv/pcs_rx_tb.sv

// File: Makefile
TOP  := pcs_rx_tb
SRCS := $(filter-out +%,$(shell cat files.f)) design/pcs_rx_macros.svh

.PHONY: all run clean

all: run

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
